/* spi_bridge_pkg.sv */
// SPI bridge shared definitions

`default_nettype none

package spi_bridge_pkg;

    // the parallel bus has a 17-bit byte address
    localparam int ADDR_WIDTH = 17;

    // every SPI transfer and every bus cycle moves one byte
    localparam int DATA_WIDTH = 8;

    // the command byte is the first byte of each transaction
    // bits 5 to 1 are reserved and the decoder never looks at them
    localparam int CMD_RW_N_BIT = 7;

    // when clear the bridge reuses the previous address plus one
    localparam int CMD_SET_ADDR_BIT = 6;

    // address bit 16 rides in the command byte since the two address bytes
    // only carry bits 15 to 0
    localparam int CMD_ADDR16_BIT = 0;

endpackage

`default_nettype wire

/* spi_byte.sv */
// SPI mode 0 byte shifter

`timescale 1ns/1ps
`default_nettype none

module spi_byte #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                                  clk_sys_i,
    input  logic                                  rst_n_i,
    input  logic                                  spi_sclk_i,
    input  logic                                  spi_cs_n_i,
    input  logic                                  spi_mosi_i,
    input  logic [spi_bridge_pkg::DATA_WIDTH-1:0] tx_byte_i,
    output logic                                  spi_miso_o,
    output logic [spi_bridge_pkg::DATA_WIDTH-1:0] rx_byte_o,
    output logic                                  rx_valid_o,
    output logic                                  cs_active_o,
    output logic                                  cs_release_o
);
    localparam int DW        = spi_bridge_pkg::DATA_WIDTH;
    localparam int CNT_WIDTH = $clog2(DW);

    logic [SYNC_STAGES-1:0] sclk_sync;
    logic [SYNC_STAGES-1:0] cs_n_sync;
    logic [SYNC_STAGES-1:0] mosi_sync;
    logic                   sclk_prev;
    logic                   cs_n_prev;
    logic                   sclk_s;
    logic                   cs_n_s;
    logic                   mosi_s;
    logic                   sclk_rise;
    logic                   sclk_fall;
    logic                   last_bit;
    logic [CNT_WIDTH-1:0]   bit_cnt;
    logic [DW-1:0]          rx_shift;
    logic [DW-1:0]          tx_shift;

    // the SPI pins are asynchronous to clk_sys_i, so each one passes a flop chain
    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            sclk_sync <= '0;
            cs_n_sync <= '1;
            mosi_sync <= '0;
            sclk_prev <= 1'b0;
            cs_n_prev <= 1'b1;
        end else begin
            sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], spi_sclk_i};
            cs_n_sync <= {cs_n_sync[SYNC_STAGES-2:0], spi_cs_n_i};
            mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], spi_mosi_i};
            sclk_prev <= sclk_s;
            cs_n_prev <= cs_n_s;
        end
    end

    assign sclk_s       = sclk_sync[SYNC_STAGES-1];
    assign cs_n_s       = cs_n_sync[SYNC_STAGES-1];
    assign mosi_s       = mosi_sync[SYNC_STAGES-1];
    assign sclk_rise    = sclk_s & ~sclk_prev & ~cs_n_s;
    assign sclk_fall    = ~sclk_s & sclk_prev & ~cs_n_s;
    assign last_bit     = (bit_cnt == CNT_WIDTH'(DW - 1));
    assign cs_active_o  = ~cs_n_s;
    assign cs_release_o = cs_n_s & ~cs_n_prev;

    // the counter wraps after eight rising edges, ready for the next byte
    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            bit_cnt    <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (cs_n_s) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                bit_cnt    <= bit_cnt + 1'b1;
                rx_valid_o <= last_bit;
            end
        end
    end

    always_ff @(posedge clk_sys_i) begin
        if (sclk_rise) begin
            rx_shift <= {rx_shift[DW-2:0], mosi_s};
            if (last_bit) begin
                rx_byte_o <= {rx_shift[DW-2:0], mosi_s};
            end
        end
    end

    // mode 0 needs the MSB on MISO before the first rising edge, hence the preload
    // a falling edge with the counter back at zero follows the eighth bit
    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            tx_shift <= '0;
        end else if (cs_n_s) begin
            tx_shift <= tx_byte_i;
        end else if (sclk_fall) begin
            if (bit_cnt == '0) begin
                tx_shift <= tx_byte_i;
            end else begin
                tx_shift <= {tx_shift[DW-2:0], 1'b0};
            end
        end
    end

    assign spi_miso_o = tx_shift[DW-1];

endmodule

`default_nettype wire

/* spi_cmd_decoder.sv */
// SPI bridge command decoder
// parses command, data and address bytes into one bus request

`timescale 1ns/1ps
`default_nettype none

module spi_cmd_decoder (
    input  logic                                  clk_sys_i,
    input  logic                                  rst_n_i,
    input  logic [spi_bridge_pkg::DATA_WIDTH-1:0] rx_byte_i,
    input  logic                                  rx_valid_i,
    input  logic                                  cs_active_i,
    input  logic                                  cs_release_i,
    output logic [spi_bridge_pkg::ADDR_WIDTH-1:0] req_addr_o,
    output logic [spi_bridge_pkg::DATA_WIDTH-1:0] req_data_o,
    output logic                                  req_rw_n_o,
    output logic                                  req_start_o
);
    localparam int AW = spi_bridge_pkg::ADDR_WIDTH;
    localparam int DW = spi_bridge_pkg::DATA_WIDTH;

    logic [1:0] byte_cnt;
    logic       set_addr_q;
    logic       cmd_done;
    logic       byte_ok;
    logic       is_cmd;
    logic       cur_rw_n;
    logic       cur_set_addr;
    logic [1:0] last_idx;
    logic [1:0] addr_hi_idx;

    // once the request has gone out, further bytes in the same frame are dropped
    assign byte_ok = rx_valid_i & cs_active_i & ~cmd_done;
    assign is_cmd  = (byte_cnt == 2'd0);

    // on the command byte itself the flags are not latched yet
    assign cur_rw_n     = is_cmd ? rx_byte_i[spi_bridge_pkg::CMD_RW_N_BIT] : req_rw_n_o;
    assign cur_set_addr = is_cmd ? rx_byte_i[spi_bridge_pkg::CMD_SET_ADDR_BIT] : set_addr_q;

    // index of the final byte for each of the four command layouts
    always_comb begin
        case ({cur_set_addr, cur_rw_n})
            2'b00:   last_idx = 2'd1;
            2'b01:   last_idx = 2'd0;
            2'b10:   last_idx = 2'd3;
            default: last_idx = 2'd2;
        endcase
    end

    // a write carries its data byte ahead of the address bytes
    assign addr_hi_idx = req_rw_n_o ? 2'd1 : 2'd2;

    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            byte_cnt    <= '0;
            cmd_done    <= 1'b0;
            set_addr_q  <= 1'b0;
            req_rw_n_o  <= 1'b0;
            req_addr_o  <= '0;
            req_start_o <= 1'b0;
        end else begin
            req_start_o <= 1'b0;
            if (cs_release_i) begin
                byte_cnt <= '0;
                cmd_done <= 1'b0;
            end else if (byte_ok) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == last_idx) begin
                    cmd_done    <= 1'b1;
                    req_start_o <= 1'b1;
                end
                if (is_cmd) begin
                    req_rw_n_o <= rx_byte_i[spi_bridge_pkg::CMD_RW_N_BIT];
                    set_addr_q <= rx_byte_i[spi_bridge_pkg::CMD_SET_ADDR_BIT];
                    if (rx_byte_i[spi_bridge_pkg::CMD_SET_ADDR_BIT]) begin
                        req_addr_o[AW-1] <= rx_byte_i[spi_bridge_pkg::CMD_ADDR16_BIT];
                    end else begin
                        // the increment wraps from 1FFFF back to 0
                        req_addr_o <= req_addr_o + 1'b1;
                    end
                end else if (set_addr_q) begin
                    if (byte_cnt == addr_hi_idx) begin
                        req_addr_o[2*DW-1:DW] <= rx_byte_i;
                    end else if (byte_cnt == addr_hi_idx + 2'd1) begin
                        req_addr_o[DW-1:0] <= rx_byte_i;
                    end
                end
            end
        end
    end

    // the data byte always directly follows the command of a write
    always_ff @(posedge clk_sys_i) begin
        if (byte_ok && !req_rw_n_o && byte_cnt == 2'd1) begin
            req_data_o <= rx_byte_i;
        end
    end

endmodule

`default_nettype wire

/* spi_bus_port.sv */
// SPI bridge parallel bus port

`timescale 1ns/1ps
`default_nettype none

module spi_bus_port (
    input  logic                                  clk_sys_i,
    input  logic                                  rst_n_i,
    input  logic [spi_bridge_pkg::ADDR_WIDTH-1:0] req_addr_i,
    input  logic [spi_bridge_pkg::DATA_WIDTH-1:0] req_data_i,
    input  logic                                  req_rw_n_i,
    input  logic                                  req_start_i,
    input  logic                                  cs_release_i,
    output logic [spi_bridge_pkg::ADDR_WIDTH-1:0] bus_addr_o,
    output logic [spi_bridge_pkg::DATA_WIDTH-1:0] bus_data_o,
    output logic                                  bus_rw_n_o,
    output logic                                  bus_valid_o,
    input  logic [spi_bridge_pkg::DATA_WIDTH-1:0] bus_data_i,
    input  logic                                  bus_ready_i,
    output logic                                  bus_done_o,
    output logic [spi_bridge_pkg::DATA_WIDTH-1:0] rd_byte_o
);
    logic accept;
    logic complete;

    assign accept   = req_start_i & ~bus_valid_o;
    assign complete = bus_valid_o & bus_ready_i;

    // the request is only loaded on accept, so it holds still while ready is low
    always_ff @(posedge clk_sys_i) begin
        if (accept) begin
            bus_addr_o <= req_addr_i;
            bus_data_o <= req_data_i;
            bus_rw_n_o <= req_rw_n_i;
        end
    end

    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            bus_valid_o <= 1'b0;
            bus_done_o  <= 1'b0;
        end else begin
            if (accept) begin
                bus_valid_o <= 1'b1;
            end else if (complete) begin
                bus_valid_o <= 1'b0;
            end
            // done stays up for the rest of the frame and drops when chip select rises
            if (complete) begin
                bus_done_o <= 1'b1;
            end else if (cs_release_i) begin
                bus_done_o <= 1'b0;
            end
        end
    end

    // the read byte goes back to the host in the first byte of the next frame
    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            rd_byte_o <= '0;
        end else if (complete && bus_rw_n_o) begin
            rd_byte_o <= bus_data_i;
        end
    end

endmodule

`default_nettype wire

/* spi_bridge_top.sv */
// SPI to parallel bus bridge

`timescale 1ns/1ps
`default_nettype none

module spi_bridge_top #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                                  clk_sys_i,
    input  logic                                  rst_n_i,
    input  logic                                  spi_sclk_i,
    input  logic                                  spi_cs_n_i,
    input  logic                                  spi_mosi_i,
    output logic                                  spi_miso_o,
    output logic [spi_bridge_pkg::ADDR_WIDTH-1:0] bus_addr_o,
    output logic [spi_bridge_pkg::DATA_WIDTH-1:0] bus_data_o,
    output logic                                  bus_rw_n_o,
    output logic                                  bus_valid_o,
    input  logic [spi_bridge_pkg::DATA_WIDTH-1:0] bus_data_i,
    input  logic                                  bus_ready_i,
    output logic                                  bus_done_o
);
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] rx_byte;
    logic                                  rx_valid;
    logic                                  cs_active;
    logic                                  cs_release;
    logic [spi_bridge_pkg::ADDR_WIDTH-1:0] req_addr;
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] req_data;
    logic                                  req_rw_n;
    logic                                  req_start;
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] rd_byte;

    spi_byte #(
        .SYNC_STAGES (SYNC_STAGES)
    ) spi_byte_inst (
        .clk_sys_i    (clk_sys_i),
        .rst_n_i      (rst_n_i),
        .spi_sclk_i   (spi_sclk_i),
        .spi_cs_n_i   (spi_cs_n_i),
        .spi_mosi_i   (spi_mosi_i),
        .tx_byte_i    (rd_byte),
        .spi_miso_o   (spi_miso_o),
        .rx_byte_o    (rx_byte),
        .rx_valid_o   (rx_valid),
        .cs_active_o  (cs_active),
        .cs_release_o (cs_release)
    );

    spi_cmd_decoder spi_cmd_decoder_inst (
        .clk_sys_i    (clk_sys_i),
        .rst_n_i      (rst_n_i),
        .rx_byte_i    (rx_byte),
        .rx_valid_i   (rx_valid),
        .cs_active_i  (cs_active),
        .cs_release_i (cs_release),
        .req_addr_o   (req_addr),
        .req_data_o   (req_data),
        .req_rw_n_o   (req_rw_n),
        .req_start_o  (req_start)
    );

    spi_bus_port spi_bus_port_inst (
        .clk_sys_i    (clk_sys_i),
        .rst_n_i      (rst_n_i),
        .req_addr_i   (req_addr),
        .req_data_i   (req_data),
        .req_rw_n_i   (req_rw_n),
        .req_start_i  (req_start),
        .cs_release_i (cs_release),
        .bus_addr_o   (bus_addr_o),
        .bus_data_o   (bus_data_o),
        .bus_rw_n_o   (bus_rw_n_o),
        .bus_valid_o  (bus_valid_o),
        .bus_data_i   (bus_data_i),
        .bus_ready_i  (bus_ready_i),
        .bus_done_o   (bus_done_o),
        .rd_byte_o    (rd_byte)
    );

endmodule

`default_nettype wire

/* tb_spi_bridge.sv */
// SPI bridge testbench
// SPI host, bus memory model and checks

`timescale 1ns/1ps
`default_nettype none

module tb_spi_bridge;
    localparam int AW             = spi_bridge_pkg::ADDR_WIDTH;
    localparam int DW             = spi_bridge_pkg::DATA_WIDTH;
    localparam int MEM_SIZE       = 1 << AW;
    localparam int HALF_CYCLES    = 25;
    localparam int DONE_TIMEOUT   = 100;
    localparam int TRANS_LIMIT_NS = 60_000;

    logic          clk_sys_i;
    logic          rst_n_i     = 1'b0;
    logic          spi_sclk_i  = 1'b0;
    logic          spi_cs_n_i  = 1'b1;
    logic          spi_mosi_i  = 1'b0;
    logic          spi_miso_o;
    logic [AW-1:0] bus_addr_o;
    logic [DW-1:0] bus_data_o;
    logic          bus_rw_n_o;
    logic          bus_valid_o;
    logic [DW-1:0] bus_data_i  = '0;
    logic          bus_ready_i = 1'b0;
    logic          bus_done_o;

    logic [DW-1:0] mem [MEM_SIZE];
    logic [DW-1:0] ref_mem [MEM_SIZE];
    logic          rw_q [$];
    logic          set_q [$];
    logic [AW-1:0] addr_q [$];
    logic [DW-1:0] data_q [$];
    logic [DW-1:0] exp_q [$];
    int            n_trans     = 0;
    int            err_count   = 0;
    int            check_count = 0;
    int            req_count   = 0;
    logic [AW-1:0] seen_addr;
    logic [DW-1:0] seen_data;
    logic          seen_rw_n;

    spi_bridge_top #(
        .SYNC_STAGES (2)
    ) spi_bridge_top_inst (
        .clk_sys_i   (clk_sys_i),
        .rst_n_i     (rst_n_i),
        .spi_sclk_i  (spi_sclk_i),
        .spi_cs_n_i  (spi_cs_n_i),
        .spi_mosi_i  (spi_mosi_i),
        .spi_miso_o  (spi_miso_o),
        .bus_addr_o  (bus_addr_o),
        .bus_data_o  (bus_data_o),
        .bus_rw_n_o  (bus_rw_n_o),
        .bus_valid_o (bus_valid_o),
        .bus_data_i  (bus_data_i),
        .bus_ready_i (bus_ready_i),
        .bus_done_o  (bus_done_o)
    );

    initial begin
        clk_sys_i = 1'b0;
        forever #10 clk_sys_i = ~clk_sys_i;
    end

    // memory contents before any write mix all 17 address bits
    function automatic logic [DW-1:0] fill_byte(input logic [AW-1:0] a);
        return a[7:0] ^ a[15:8] ^ (a[16] ? 8'hA5 : 8'h00);
    endfunction

    function automatic string op_name(input logic rw_n, input logic with_addr);
        if (rw_n && with_addr) return "R";
        if (rw_n) return "RN";
        if (with_addr) return "W";
        return "WN";
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic half_period();
        repeat (HALF_CYCLES) @(posedge clk_sys_i);
    endtask

    // the mode 0 host sets MOSI while SCLK is low and samples MISO on the rising edge
    task automatic shift_byte(input logic [DW-1:0] tx, output logic [DW-1:0] rx);
        for (int i = DW - 1; i >= 0; i--) begin
            spi_mosi_i <= tx[i];
            half_period();
            spi_sclk_i <= 1'b1;
            rx[i] = spi_miso_o;
            half_period();
            spi_sclk_i <= 1'b0;
        end
    endtask

    // bus memory that answers each request after 0 to 7 cycles
    initial begin : memory_model
        int   seed;
        int   wait_left;
        logic serving;
        seed = 19;
        wait_left = 0;
        serving = 1'b0;
        for (int a = 0; a < MEM_SIZE; a++) begin
            mem[a] = fill_byte(AW'(a));
        end
        forever begin
            @(posedge clk_sys_i);
            bus_ready_i <= 1'b0;
            if (bus_valid_o && !bus_ready_i) begin
                // done may only rise once the bus has answered
                check_value("bus_done_o", 32'(bus_done_o), 0);
                if (!serving) begin
                    serving = 1'b1;
                    wait_left = int'($unsigned($random(seed)) % 8);
                    seen_addr = bus_addr_o;
                    seen_data = bus_data_o;
                    seen_rw_n = bus_rw_n_o;
                    req_count++;
                end else begin
                    // the request must not move while ready is held low
                    check_value("bus_addr_o", 32'(bus_addr_o), 32'(seen_addr));
                    check_value("bus_data_o", 32'(bus_data_o), 32'(seen_data));
                    check_value("bus_rw_n_o", 32'(bus_rw_n_o), 32'(seen_rw_n));
                end
                if (wait_left == 0) begin
                    bus_ready_i <= 1'b1;
                    bus_data_i  <= mem[bus_addr_o];
                    if (!bus_rw_n_o) begin
                        mem[bus_addr_o] <= bus_data_o;
                    end
                    serving = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin : watchdog
        wait (n_trans > 0);
        #((n_trans + 1) * TRANS_LIMIT_NS);
        $display("watchdog expired before %0d transactions completed", n_trans);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : stimulus
        int            fd;
        int            code;
        int            cycles;
        int            errs_before;
        int            count_before;
        logic [63:0]   tok;
        logic [1023:0] junk;
        logic [AW-1:0] f_addr;
        logic [DW-1:0] f_data;
        logic [DW-1:0] f_exp;
        logic [AW-1:0] exp_addr;
        logic [DW-1:0] pend_exp;
        logic [DW-1:0] first_rx;
        logic [DW-1:0] rx_byte;
        logic [DW-1:0] cmd;
        logic [DW-1:0] tx_q [$];
        logic          rw_n;
        logic          with_addr;

        for (int a = 0; a < MEM_SIZE; a++) begin
            ref_mem[a] = fill_byte(AW'(a));
        end
        fd = $fopen("spi_bridge_input.txt", "r");
        assert (fd != 0) else begin
            $display("could not open spi_bridge_input.txt");
            err_count++;
        end
        if (fd != 0) begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == 64'("#")) begin
                    code = $fgets(junk, fd);
                end else begin
                    code = $fscanf(fd, "%h %h %h", f_addr, f_data, f_exp);
                    assert (code == 3 && (tok == 64'("W") || tok == 64'("WN") ||
                            tok == 64'("R") || tok == 64'("RN"))) else begin
                        $display("data file entry %0d is malformed", rw_q.size());
                        err_count++;
                    end
                    rw_q.push_back(tok == 64'("R") || tok == 64'("RN"));
                    set_q.push_back(tok == 64'("W") || tok == 64'("R"));
                    addr_q.push_back(f_addr);
                    data_q.push_back(f_data);
                    exp_q.push_back(f_exp);
                end
            end
            $fclose(fd);
        end
        n_trans = rw_q.size();

        repeat (10) @(posedge clk_sys_i);
        rst_n_i <= 1'b1;
        @(posedge clk_sys_i);
        check_value("bus_valid_o", 32'(bus_valid_o), 0);
        check_value("bus_done_o", 32'(bus_done_o), 0);
        check_value("spi_miso_o", 32'(spi_miso_o), 0);

        // the address register and the read byte both start at zero
        exp_addr = '0;
        pend_exp = '0;
        for (int t = 0; t < n_trans; t++) begin
            errs_before = err_count;
            rw_n = rw_q[t];
            with_addr = set_q[t];
            if (with_addr) begin
                exp_addr = addr_q[t];
            end else begin
                exp_addr = exp_addr + 1'b1;
            end
            assert (addr_q[t] == exp_addr) else begin
                $display("data file address %05h of transaction %0d breaks the increment rule",
                         addr_q[t], t);
                err_count++;
            end

            // next commands carry reserved bits and bit 0 set, which must be ignored
            cmd = {rw_n, with_addr, 6'h00};
            if (with_addr) begin
                cmd[0] = exp_addr[16];
            end else begin
                cmd[5:0] = 6'h3F;
            end
            tx_q.delete();
            tx_q.push_back(cmd);
            if (!rw_n) begin
                tx_q.push_back(data_q[t]);
            end
            if (with_addr) begin
                tx_q.push_back(exp_addr[15:8]);
                tx_q.push_back(exp_addr[7:0]);
            end

            count_before = req_count;
            spi_cs_n_i <= 1'b0;
            first_rx = '0;
            for (int b = 0; b < tx_q.size(); b++) begin
                shift_byte(tx_q[b], rx_byte);
                if (b == 0) begin
                    first_rx = rx_byte;
                end
            end
            check_value("spi_miso_o", 32'(first_rx), 32'(pend_exp));

            cycles = 0;
            while (!bus_done_o && cycles < DONE_TIMEOUT) begin
                @(posedge clk_sys_i);
                cycles++;
            end
            assert (bus_done_o) else begin
                $display("bus_done_o did not rise within %0d cycles of the last bit",
                         DONE_TIMEOUT);
                err_count++;
            end
            assert (req_count == count_before + 1) else begin
                $display("expected one bus request but saw %0d", req_count - count_before);
                err_count++;
            end
            check_value("bus_addr_o", 32'(seen_addr), 32'(exp_addr));
            check_value("bus_rw_n_o", 32'(seen_rw_n), 32'(rw_n));
            if (!rw_n) begin
                check_value("bus_data_o", 32'(seen_data), 32'(data_q[t]));
                ref_mem[exp_addr] = data_q[t];
            end else begin
                assert (exp_q[t] == ref_mem[exp_addr]) else begin
                    $display("data file expects %02h at %05h but the memory copy holds %02h",
                             exp_q[t], exp_addr, ref_mem[exp_addr]);
                    err_count++;
                end
                pend_exp = ref_mem[exp_addr];
            end

            half_period();
            spi_cs_n_i <= 1'b1;
            cycles = 0;
            while (bus_done_o && cycles < 10) begin
                @(posedge clk_sys_i);
                cycles++;
            end
            assert (!bus_done_o) else begin
                $display("bus_done_o stayed high after chip select rose");
                err_count++;
            end
            repeat (10) @(posedge clk_sys_i);
            $display("%0t ns transaction %0d %s addr %05h: %s", $time, t,
                     op_name(rw_n, with_addr), exp_addr,
                     (err_count == errs_before) ? "pass" : "fail");
        end

        $display("%0d transactions, %0d value checks, %0d errors",
                 n_trans, check_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pet_spi_bridge.f */
spi_bridge_pkg.sv
spi_byte.sv
spi_cmd_decoder.sv
spi_bus_port.sv
spi_bridge_top.sv
tb_spi_bridge.sv

/* Makefile */
# Verilator flow for the SPI to parallel bus bridge

VERILATOR ?= verilator
FILE_LIST ?= pet_spi_bridge.f
TB_TOP    ?= tb_spi_bridge
RTL_TOP   ?= spi_bridge_top
RTL_SRCS  ?= spi_bridge_pkg.sv spi_byte.sv spi_cmd_decoder.sv spi_bus_port.sv spi_bridge_top.sv
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILE_LIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* spi_bridge_input.txt */
# op addr data expected, all values hex
# op is W, WN, R or RN and next ops list the incremented address
W  00010 11 00
WN 00011 22 00
WN 00012 33 00
R  00010 00 11
RN 00011 00 22
RN 00012 00 33
W  0ABCD 5A 00
R  0ABCD 00 5A
W  1FFFF 3C 00
WN 00000 7E 00
R  1FFFF 00 3C
RN 00000 00 7E
W  1F0F0 C5 00
WN 1F0F1 9D 00
R  12345 00 C3
RN 12346 00 C0
R  1F0F0 00 C5
RN 1F0F1 00 9D
W  00020 01 00
